// ==== Makefile ====
TB_TOP = tb_axi_wr_demux

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --timescale 1ns/1ps -f sources.f --top-module axi_wr_demux

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps -f sources.f \
		--top-module $(TB_TOP) -Mdir obj_dir
	./obj_dir/V$(TB_TOP) | tee sim.log
	grep -q '^>>> PASS$$' sim.log

clean:
	rm -rf obj_dir sim.log

// ==== common/axi_demux_config.svh ====
// write-path build settings; NUM_MST must be a power of two and at least 2, LOOK_BITS <= ID_W
`ifndef AXI_DEMUX_CONFIG_SVH
`define AXI_DEMUX_CONFIG_SVH

// number of master ports behind the demux
`define NUM_MST 4

// AXI field widths
`define ID_W 4
`define ADDR_W 32
`define DATA_W 32

// low ID bits that index the tracking table, IDs sharing them alias
`define LOOK_BITS 3

// writes allowed in flight at once, also the W select FIFO depth
`define MAX_TRANS 8

`endif

// ==== common/demux_chan_pkg.sv ====
// AXI write-channel payloads and bundles; no user, lock, cache, prot, qos or atop fields
`include "axi_demux_config.svh"

package demux_chan_pkg;

    // write address, only the fields the demux carries
    typedef struct packed {
        logic [`ID_W-1:0]   id;
        logic [`ADDR_W-1:0] addr;
        logic [7:0]         len;
        logic [2:0]         size;
    } aw_chan_t;

    // write data beat
    typedef struct packed {
        logic [`DATA_W-1:0]   data;
        logic [`DATA_W/8-1:0] strb;
        logic                 last;
    } w_chan_t;

    // write response
    typedef struct packed {
        logic [`ID_W-1:0] id;
        logic [1:0]       resp;
    } b_chan_t;

    // manager to subordinate direction
    typedef struct packed {
        logic     aw_valid;
        aw_chan_t aw;
        logic     w_valid;
        w_chan_t  w;
        logic     b_ready;
    } wr_req_t;

    // subordinate to manager direction
    typedef struct packed {
        logic    aw_ready;
        logic    w_ready;
        logic    b_valid;
        b_chan_t b;
    } wr_resp_t;

endpackage

// ==== common/demux_route_pkg.sv ====
// routing types for the write demux; sel_t width follows NUM_MST, cnt_t must hold MAX_TRANS
`include "axi_demux_config.svh"

package demux_route_pkg;

    // index of a master port
    typedef logic [$clog2(`NUM_MST)-1:0] sel_t;

    // tracking table slot, the low ID bits
    typedef logic [`LOOK_BITS-1:0] look_idx_t;

    // outstanding write count, 0 up to MAX_TRANS
    typedef logic [$clog2(`MAX_TRANS+1)-1:0] cnt_t;

    // AW admission FSM, one-hot
    typedef enum logic [1:0] {
        ADM_IDLE = 2'b01,
        ADM_FWD  = 2'b10
    } adm_state_e;

    // W steering FSM, one-hot
    typedef enum logic [1:0] {
        WST_IDLE  = 2'b01,
        WST_BURST = 2'b10
    } wst_state_e;

endpackage

// ==== hw/aw_route/aw_admit.sv ====
// AW admission, write path only with no atomics; slv_aw_sel_i must hold stable with aw_valid
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module aw_admit (
    input  logic                              clk_i,
    input  logic                              rst_ni,
    // slave AW
    input  logic                              slv_aw_valid_i,
    input  demux_chan_pkg::aw_chan_t          slv_aw_i,
    input  demux_route_pkg::sel_t             slv_aw_sel_i,
    output logic                              slv_aw_ready_o,
    // table lookup
    output demux_route_pkg::look_idx_t        lookup_slot_o,
    input  logic                              slot_taken_i,
    input  demux_route_pkg::sel_t             slot_sel_i,
    input  logic                              trans_full_i,
    // push towards table and W steering
    output logic                              push_o,
    output demux_route_pkg::sel_t             push_sel_o,
    output demux_route_pkg::look_idx_t        push_slot_o,
    // master AW
    output logic [`NUM_MST-1:0]               mst_aw_valid_o,
    output demux_chan_pkg::aw_chan_t          mst_aw_o,
    input  logic [`NUM_MST-1:0]               mst_aw_ready_i
);

    demux_route_pkg::adm_state_e state_q, state_d;
    demux_route_pkg::sel_t       sel_q, sel_d;
    demux_route_pkg::look_idx_t  slot_q, slot_d;
    logic                        admit_ok;
    logic                        aw_hs;

    assign lookup_slot_o = slv_aw_i.id[`LOOK_BITS-1:0];

    // same slot may only stay on the master it already uses
    assign admit_ok = slv_aw_valid_i && !trans_full_i &&
                      (!slot_taken_i || (slot_sel_i == slv_aw_sel_i));

    assign aw_hs = (state_q == demux_route_pkg::ADM_FWD) &&
                   slv_aw_valid_i && mst_aw_ready_i[sel_q];

    always_comb begin
        state_d = state_q;
        sel_d   = sel_q;
        slot_d  = slot_q;
        case (state_q)
            demux_route_pkg::ADM_IDLE: begin
                if (admit_ok) begin
                    state_d = demux_route_pkg::ADM_FWD;
                    sel_d   = slv_aw_sel_i;
                    slot_d  = lookup_slot_o;
                end
            end
            demux_route_pkg::ADM_FWD: begin
                // master back-pressure keeps us here
                if (aw_hs) begin
                    state_d = demux_route_pkg::ADM_IDLE;
                end
            end
            default: state_d = demux_route_pkg::ADM_IDLE;
        endcase
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q <= demux_route_pkg::ADM_IDLE;
            sel_q   <= '0;
            slot_q  <= '0;
        end else begin
            state_q <= state_d;
            sel_q   <= sel_d;
            slot_q  <= slot_d;
        end
    end

    // forward only to the latched master
    always_comb begin
        mst_aw_valid_o = '0;
        slv_aw_ready_o = 1'b0;
        if (state_q == demux_route_pkg::ADM_FWD) begin
            mst_aw_valid_o[sel_q] = slv_aw_valid_i;
            slv_aw_ready_o        = mst_aw_ready_i[sel_q];
        end
    end

    assign mst_aw_o    = slv_aw_i;
    assign push_o      = aw_hs;
    assign push_sel_o  = sel_q;
    assign push_slot_o = slot_q;

endmodule

// ==== hw/aw_route/id_track_table.sv ====
// outstanding write tracking per ID slot; IDs alias by LOOK_BITS low bits, total capped by MAX_TRANS
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module id_track_table (
    input  logic                       clk_i,
    input  logic                       rst_ni,
    // lookup for admission
    input  demux_route_pkg::look_idx_t lookup_slot_i,
    output logic                       slot_taken_o,
    output demux_route_pkg::sel_t      slot_sel_o,
    output logic                       trans_full_o,
    // new write admitted
    input  logic                       push_i,
    input  demux_route_pkg::look_idx_t push_slot_i,
    input  demux_route_pkg::sel_t      push_sel_i,
    // B accepted on the slave port
    input  logic                       retire_i,
    input  demux_route_pkg::look_idx_t retire_slot_i
);

    localparam int NUM_SLOTS = 2 ** `LOOK_BITS;

    demux_route_pkg::cnt_t cnt_q [NUM_SLOTS];
    demux_route_pkg::sel_t sel_q [NUM_SLOTS];
    demux_route_pkg::cnt_t total_q;

    for (genvar i = 0; i < NUM_SLOTS; i++) begin : g_slot
        logic inc;
        logic dec;

        assign inc = push_i && (push_slot_i == demux_route_pkg::look_idx_t'(i));
        assign dec = retire_i && (retire_slot_i == demux_route_pkg::look_idx_t'(i));

        always_ff @(posedge clk_i or negedge rst_ni) begin
            if (!rst_ni) begin
                cnt_q[i] <= '0;
            end else if (inc && !dec) begin
                cnt_q[i] <= cnt_q[i] + 1'b1;
            end else if (dec && !inc) begin
                cnt_q[i] <= cnt_q[i] - 1'b1;
            end
        end

        // target only matters while the count is nonzero
        always_ff @(posedge clk_i) begin
            if (inc) begin
                sel_q[i] <= push_sel_i;
            end
        end
    end

    // push and retire in one cycle cancel out
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            total_q <= '0;
        end else if (push_i && !retire_i) begin
            total_q <= total_q + 1'b1;
        end else if (retire_i && !push_i) begin
            total_q <= total_q - 1'b1;
        end
    end

    assign slot_taken_o = (cnt_q[lookup_slot_i] != '0);
    assign slot_sel_o   = sel_q[lookup_slot_i];
    assign trans_full_o = (total_q == demux_route_pkg::cnt_t'(`MAX_TRANS));

endmodule

// ==== hw/axi_wr_demux.sv ====
// AXI write demux top, one slave port to NUM_MST masters; AW select arrives with aw_valid
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module axi_wr_demux (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,
    // slave port
    input  demux_chan_pkg::wr_req_t                 slv_req_i,
    input  demux_route_pkg::sel_t                   slv_aw_sel_i,
    output demux_chan_pkg::wr_resp_t                slv_resp_o,
    // master ports
    output demux_chan_pkg::wr_req_t [`NUM_MST-1:0]  mst_req_o,
    input  demux_chan_pkg::wr_resp_t [`NUM_MST-1:0] mst_resp_i
);

    logic [`NUM_MST-1:0]                    mst_aw_valid, mst_aw_ready;
    logic [`NUM_MST-1:0]                    mst_w_valid, mst_w_ready;
    logic [`NUM_MST-1:0]                    mst_b_valid, mst_b_ready;
    demux_chan_pkg::aw_chan_t               mst_aw;
    demux_chan_pkg::w_chan_t                mst_w;
    demux_chan_pkg::b_chan_t [`NUM_MST-1:0] mst_b;
    demux_chan_pkg::b_chan_t                slv_b;
    logic                                   slv_aw_ready, slv_w_ready, slv_b_valid;
    demux_route_pkg::look_idx_t             lookup_slot, push_slot, retire_slot;
    demux_route_pkg::sel_t                  slot_sel, push_sel;
    logic                                   slot_taken, trans_full, push, retire;

    aw_admit u_aw_admit (
        .clk_i, .rst_ni,
        .slv_aw_valid_i (slv_req_i.aw_valid), .slv_aw_i (slv_req_i.aw),
        .slv_aw_sel_i, .slv_aw_ready_o (slv_aw_ready),
        .lookup_slot_o (lookup_slot), .slot_taken_i (slot_taken),
        .slot_sel_i (slot_sel), .trans_full_i (trans_full),
        .push_o (push), .push_sel_o (push_sel), .push_slot_o (push_slot),
        .mst_aw_valid_o (mst_aw_valid), .mst_aw_o (mst_aw), .mst_aw_ready_i (mst_aw_ready)
    );

    id_track_table u_id_track_table (
        .clk_i, .rst_ni,
        .lookup_slot_i (lookup_slot), .slot_taken_o (slot_taken),
        .slot_sel_o (slot_sel), .trans_full_o (trans_full),
        .push_i (push), .push_slot_i (push_slot), .push_sel_i (push_sel),
        .retire_i (retire), .retire_slot_i (retire_slot)
    );

    w_steer u_w_steer (
        .clk_i, .rst_ni,
        .push_i (push), .push_sel_i (push_sel),
        .slv_w_valid_i (slv_req_i.w_valid), .slv_w_i (slv_req_i.w), .slv_w_ready_o (slv_w_ready),
        .mst_w_valid_o (mst_w_valid), .mst_w_o (mst_w), .mst_w_ready_i (mst_w_ready)
    );

    b_arbiter u_b_arbiter (
        .clk_i, .rst_ni,
        .mst_b_valid_i (mst_b_valid), .mst_b_i (mst_b), .mst_b_ready_o (mst_b_ready),
        .slv_b_valid_o (slv_b_valid), .slv_b_o (slv_b), .slv_b_ready_i (slv_req_i.b_ready),
        .retire_o (retire), .retire_slot_o (retire_slot)
    );

    // pack per-channel signals back into bundles
    always_comb begin
        for (int i = 0; i < `NUM_MST; i++) begin
            mst_aw_ready[i]     = mst_resp_i[i].aw_ready;
            mst_w_ready[i]      = mst_resp_i[i].w_ready;
            mst_b_valid[i]      = mst_resp_i[i].b_valid;
            mst_b[i]            = mst_resp_i[i].b;
            mst_req_o[i].aw_valid = mst_aw_valid[i];
            mst_req_o[i].aw       = mst_aw;
            mst_req_o[i].w_valid  = mst_w_valid[i];
            mst_req_o[i].w        = mst_w;
            mst_req_o[i].b_ready  = mst_b_ready[i];
        end
        slv_resp_o.aw_ready = slv_aw_ready;
        slv_resp_o.w_ready  = slv_w_ready;
        slv_resp_o.b_valid  = slv_b_valid;
        slv_resp_o.b        = slv_b;
    end

endmodule

// ==== hw/b_arbiter.sv ====
// round-robin B merge with one grant per cycle; wrap-around relies on NUM_MST being a power of two
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module b_arbiter (
    input  logic                                         clk_i,
    input  logic                                         rst_ni,
    // master B
    input  logic [`NUM_MST-1:0]                          mst_b_valid_i,
    input  demux_chan_pkg::b_chan_t [`NUM_MST-1:0]       mst_b_i,
    output logic [`NUM_MST-1:0]                          mst_b_ready_o,
    // slave B
    output logic                                         slv_b_valid_o,
    output demux_chan_pkg::b_chan_t                      slv_b_o,
    input  logic                                         slv_b_ready_i,
    // retire towards the table
    output logic                                         retire_o,
    output demux_route_pkg::look_idx_t                   retire_slot_o
);

    demux_route_pkg::sel_t ptr_q;
    demux_route_pkg::sel_t gnt_idx;
    demux_route_pkg::sel_t cand;
    logic                  found;

    // first valid master at or after the pointer
    always_comb begin
        gnt_idx = ptr_q;
        found   = 1'b0;
        cand    = ptr_q;
        for (int k = 0; k < `NUM_MST; k++) begin
            cand = ptr_q + demux_route_pkg::sel_t'(k);
            if (!found && mst_b_valid_i[cand]) begin
                gnt_idx = cand;
                found   = 1'b1;
            end
        end
    end

    assign slv_b_valid_o = found;
    assign slv_b_o       = mst_b_i[gnt_idx];

    always_comb begin
        mst_b_ready_o          = '0;
        mst_b_ready_o[gnt_idx] = found && slv_b_ready_i;
    end

    assign retire_o      = found && slv_b_ready_i;
    assign retire_slot_o = slv_b_o.id[`LOOK_BITS-1:0];

    // pointer moves past the master just served
    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            ptr_q <= '0;
        end else if (retire_o) begin
            ptr_q <= gnt_idx + 1'b1;
        end
    end

endmodule

// ==== hw/w_steer.sv ====
// W burst steering in AW order; a W burst must not start before its AW is pushed
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module w_steer (
    input  logic                     clk_i,
    input  logic                     rst_ni,
    // admitted AW select
    input  logic                     push_i,
    input  demux_route_pkg::sel_t    push_sel_i,
    // slave W
    input  logic                     slv_w_valid_i,
    input  demux_chan_pkg::w_chan_t  slv_w_i,
    output logic                     slv_w_ready_o,
    // master W
    output logic [`NUM_MST-1:0]      mst_w_valid_o,
    output demux_chan_pkg::w_chan_t  mst_w_o,
    input  logic [`NUM_MST-1:0]      mst_w_ready_i
);

    localparam int PTR_W = $clog2(`MAX_TRANS);

    demux_route_pkg::sel_t      fifo_q [`MAX_TRANS];
    logic [PTR_W-1:0]           wr_ptr_q, rd_ptr_q;
    demux_route_pkg::cnt_t      count_q;
    logic                       pop;
    demux_route_pkg::wst_state_e state_q;
    demux_route_pkg::sel_t      cur_sel_q;
    logic                       last_hs;

    // table limit keeps the FIFO from overflowing
    always_ff @(posedge clk_i) begin
        if (push_i) begin
            fifo_q[wr_ptr_q] <= push_sel_i;
        end
    end

    assign pop = (state_q == demux_route_pkg::WST_IDLE) && (count_q != '0) && slv_w_valid_i;

    assign last_hs = (state_q == demux_route_pkg::WST_BURST) && slv_w_valid_i &&
                     slv_w_i.last && mst_w_ready_i[cur_sel_q];

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (push_i) begin
                wr_ptr_q <= (wr_ptr_q == PTR_W'(`MAX_TRANS - 1)) ? '0 : wr_ptr_q + 1'b1;
            end
            if (pop) begin
                rd_ptr_q <= (rd_ptr_q == PTR_W'(`MAX_TRANS - 1)) ? '0 : rd_ptr_q + 1'b1;
            end
            if (push_i && !pop) begin
                count_q <= count_q + 1'b1;
            end else if (pop && !push_i) begin
                count_q <= count_q - 1'b1;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            state_q   <= demux_route_pkg::WST_IDLE;
            cur_sel_q <= '0;
        end else if (pop) begin
            state_q   <= demux_route_pkg::WST_BURST;
            cur_sel_q <= fifo_q[rd_ptr_q];
        end else if (last_hs) begin
            state_q   <= demux_route_pkg::WST_IDLE;
        end
    end

    // whole burst goes to the popped master
    always_comb begin
        mst_w_valid_o = '0;
        slv_w_ready_o = 1'b0;
        if (state_q == demux_route_pkg::WST_BURST) begin
            mst_w_valid_o[cur_sel_q] = slv_w_valid_i;
            slv_w_ready_o            = mst_w_ready_i[cur_sel_q];
        end
    end

    assign mst_w_o = slv_w_i;

endmodule

// ==== sources.f ====
+incdir+common
common/demux_chan_pkg.sv
common/demux_route_pkg.sv
hw/aw_route/id_track_table.sv
hw/aw_route/aw_admit.sv
hw/w_steer.sv
hw/b_arbiter.sv
hw/axi_wr_demux.sv
test/axi_wr_demux_chk.sv
test/tb_axi_wr_demux.sv

// ==== test/axi_wr_demux_chk.sv ====
// protocol checks bound into the write demux; all checks are off while rst_ni is low
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module axi_wr_demux_chk (
    input logic                                   clk_i,
    input logic                                   rst_ni,
    input demux_chan_pkg::wr_req_t                slv_req_i,
    input demux_route_pkg::sel_t                  slv_aw_sel_i,
    input demux_chan_pkg::wr_resp_t               slv_resp_i,
    input demux_chan_pkg::wr_req_t [`NUM_MST-1:0] mst_req_i
);

    logic [`NUM_MST-1:0] aw_valid_vec;
    logic [`NUM_MST-1:0] w_valid_vec;

    always_comb begin
        for (int m = 0; m < `NUM_MST; m++) begin
            aw_valid_vec[m] = mst_req_i[m].aw_valid;
            w_valid_vec[m]  = mst_req_i[m].w_valid;
        end
    end

    // slave holds AW, its select and valid until accepted
    aw_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
        slv_req_i.aw_valid && !slv_resp_i.aw_ready |=>
            slv_req_i.aw_valid && $stable(slv_req_i.aw) && $stable(slv_aw_sel_i))
        else $error("slave AW changed before it was accepted");

    aw_one_master: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(aw_valid_vec))
        else $error("aw_valid high on more than one master");

    w_one_master: assert property (@(posedge clk_i) disable iff (!rst_ni)
        $onehot0(w_valid_vec))
        else $error("w_valid high on more than one master");

endmodule

bind axi_wr_demux axi_wr_demux_chk u_chk (
    .clk_i        (clk_i),
    .rst_ni       (rst_ni),
    .slv_req_i    (slv_req_i),
    .slv_aw_sel_i (slv_aw_sel_i),
    .slv_resp_i   (slv_resp_o),
    .mst_req_i    (mst_req_o)
);

// ==== test/tb_axi_wr_demux.sv ====
// directed testbench for the write demux; master models hold aw_ready and w_ready high, B on request
`timescale 1ns/1ps
`include "axi_demux_config.svh"

module tb_axi_wr_demux;

    localparam int HALF_PERIOD = 10;
    localparam int DRIVE_DLY   = 2;
    // five tests need a few hundred cycles at most, the limit leaves wide margin
    localparam int TIMEOUT_CYCLES = 2000;

    logic                                    clk_i;
    logic                                    rst_ni;
    demux_chan_pkg::wr_req_t                 slv_req;
    demux_route_pkg::sel_t                   slv_aw_sel;
    demux_chan_pkg::wr_resp_t                slv_resp;
    demux_chan_pkg::wr_req_t [`NUM_MST-1:0]  mst_req;
    demux_chan_pkg::wr_resp_t [`NUM_MST-1:0] mst_resp;
    int                                      cycles = 0;
    bit                                      fail_seen = 1'b0;
    bit                                      pass_seen = 1'b0;

    axi_wr_demux UUT (
        .clk_i        (clk_i),
        .rst_ni       (rst_ni),
        .slv_req_i    (slv_req),
        .slv_aw_sel_i (slv_aw_sel),
        .slv_resp_o   (slv_resp),
        .mst_req_o    (mst_req),
        .mst_resp_i   (mst_resp)
    );

    initial begin
        clk_i = 1'b0;
        forever #HALF_PERIOD clk_i = ~clk_i;
    end

    task automatic fail_run(input string msg);
        $display("%s", msg);
        fail_seen = 1'b1;
        $display(">>> FAIL");
        $fatal(1, "run stopped at first error");
    endtask

    always @(posedge clk_i) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            fail_run("timeout: the run did not finish within the cycle limit");
        end
    end

    // run ended by an assertion or another stop without a verdict
    final begin
        if (!pass_seen && !fail_seen) begin
            $display(">>> FAIL");
        end
    end

    task automatic wait_drive_point();
        @(posedge clk_i);
        #DRIVE_DLY;
    endtask

    // masters always accept AW and W, no B pending
    task automatic idle_inputs();
        slv_req         = '0;
        slv_req.b_ready = 1'b1;
        slv_aw_sel      = '0;
        mst_resp        = '0;
        for (int m = 0; m < `NUM_MST; m++) begin
            mst_resp[m].aw_ready = 1'b1;
            mst_resp[m].w_ready  = 1'b1;
        end
    endtask

    task automatic apply_reset();
        idle_inputs();
        rst_ni = 1'b0;
        repeat (8) @(posedge clk_i);
        #DRIVE_DLY;
        rst_ni = 1'b1;
    endtask

    function automatic demux_chan_pkg::aw_chan_t make_aw(input int id, input int len);
        demux_chan_pkg::aw_chan_t aw;
        aw.id   = id[`ID_W-1:0];
        aw.addr = $urandom();
        aw.len  = len[7:0];
        aw.size = 3'd2;
        return aw;
    endfunction

    function automatic demux_chan_pkg::b_chan_t make_b(input int id, input logic [1:0] resp);
        demux_chan_pkg::b_chan_t b;
        b.id   = id[`ID_W-1:0];
        b.resp = resp;
        return b;
    endfunction

    task automatic compare_aw(input string name, input demux_chan_pkg::aw_chan_t exp,
                              input demux_route_pkg::sel_t exp_idx);
        demux_route_pkg::sel_t act_idx;
        logic                  seen;
        act_idx = '0;
        seen    = 1'b0;
        for (int m = 0; m < `NUM_MST; m++) begin
            if (mst_req[m].aw_valid) begin
                act_idx = demux_route_pkg::sel_t'(m);
                seen    = 1'b1;
            end
        end
        if (!seen) begin
            fail_run($sformatf("%s: slave AW accepted but no master saw aw_valid", name));
        end
        if (act_idx != exp_idx) begin
            fail_run($sformatf("mismatch %s AW master expected %0d actual %0d",
                               name, exp_idx, act_idx));
        end
        if (mst_req[act_idx].aw != exp) begin
            fail_run($sformatf("mismatch %s AW payload expected %h actual %h",
                               name, exp, mst_req[act_idx].aw));
        end
    endtask

    task automatic compare_w(input string name, input demux_chan_pkg::w_chan_t exp,
                             input demux_route_pkg::sel_t exp_idx);
        demux_route_pkg::sel_t act_idx;
        logic                  seen;
        act_idx = '0;
        seen    = 1'b0;
        for (int m = 0; m < `NUM_MST; m++) begin
            if (mst_req[m].w_valid) begin
                act_idx = demux_route_pkg::sel_t'(m);
                seen    = 1'b1;
            end
        end
        if (!seen) begin
            fail_run($sformatf("%s: slave W accepted but no master saw w_valid", name));
        end
        if (act_idx != exp_idx) begin
            fail_run($sformatf("mismatch %s W master expected %0d actual %0d",
                               name, exp_idx, act_idx));
        end
        if (mst_req[act_idx].w != exp) begin
            fail_run($sformatf("mismatch %s W beat expected %h actual %h",
                               name, exp, mst_req[act_idx].w));
        end
    endtask

    task automatic compare_b(input string name, input demux_chan_pkg::b_chan_t exp);
        if (!slv_resp.b_valid) begin
            fail_run($sformatf("%s: expected a B on the slave port but b_valid is low", name));
        end
        if (slv_resp.b != exp) begin
            fail_run($sformatf("mismatch %s B expected %h actual %h", name, exp, slv_resp.b));
        end
    endtask

    task automatic start_aw(input demux_chan_pkg::aw_chan_t aw, input demux_route_pkg::sel_t sel);
        wait_drive_point();
        slv_req.aw_valid = 1'b1;
        slv_req.aw       = aw;
        slv_aw_sel       = sel;
    endtask

    // sampled mid-cycle, handshake happens on the next edge
    task automatic finish_aw(input string name, input demux_chan_pkg::aw_chan_t aw,
                             input demux_route_pkg::sel_t sel);
        @(negedge clk_i);
        while (!slv_resp.aw_ready) @(negedge clk_i);
        compare_aw(name, aw, sel);
        wait_drive_point();
        slv_req.aw_valid = 1'b0;
    endtask

    task automatic check_aw_held(input string name, input int n);
        repeat (n) begin
            @(negedge clk_i);
            for (int m = 0; m < `NUM_MST; m++) begin
                if (mst_req[m].aw_valid || slv_resp.aw_ready) begin
                    fail_run($sformatf("%s: AW reached master %0d while it must be held",
                                       name, m));
                end
            end
        end
    endtask

    task automatic send_w_burst(input string name, input int beats,
                                input demux_route_pkg::sel_t exp_idx);
        demux_chan_pkg::w_chan_t w;
        for (int beat = 0; beat < beats; beat++) begin
            w.data = $urandom();
            w.strb = '1;
            w.last = (beat == beats - 1);
            wait_drive_point();
            slv_req.w_valid = 1'b1;
            slv_req.w       = w;
            @(negedge clk_i);
            while (!slv_resp.w_ready) @(negedge clk_i);
            compare_w(name, w, exp_idx);
        end
        wait_drive_point();
        slv_req.w_valid = 1'b0;
    endtask

    task automatic return_b(input string name, input int m, input demux_chan_pkg::b_chan_t b);
        wait_drive_point();
        mst_resp[m].b_valid = 1'b1;
        mst_resp[m].b       = b;
        @(negedge clk_i);
        while (!mst_req[m].b_ready) @(negedge clk_i);
        compare_b(name, b);
        wait_drive_point();
        mst_resp[m].b_valid = 1'b0;
    endtask

    task automatic test_single_write();
        demux_chan_pkg::aw_chan_t aw;
        aw = make_aw(3, 1);
        start_aw(aw, 2'd2);
        finish_aw("single_write", aw, 2'd2);
        send_w_burst("single_write", 2, 2'd2);
        return_b("single_write", 2, make_b(3, 2'b10));
    endtask

    task automatic test_w_order();
        demux_chan_pkg::aw_chan_t aw_first;
        demux_chan_pkg::aw_chan_t aw_second;
        aw_first  = make_aw(1, 2);
        aw_second = make_aw(2, 0);
        start_aw(aw_first, 2'd1);
        finish_aw("w_order", aw_first, 2'd1);
        start_aw(aw_second, 2'd3);
        finish_aw("w_order", aw_second, 2'd3);
        // bursts only start once both AWs are queued
        send_w_burst("w_order", 3, 2'd1);
        send_w_burst("w_order", 1, 2'd3);
        return_b("w_order", 1, make_b(1, 2'b00));
        return_b("w_order", 3, make_b(2, 2'b00));
    endtask

    task automatic test_id_conflict();
        demux_chan_pkg::aw_chan_t aw_first;
        demux_chan_pkg::aw_chan_t aw_second;
        aw_first  = make_aw(5, 0);
        aw_second = make_aw(5, 0);
        start_aw(aw_first, 2'd0);
        finish_aw("id_conflict", aw_first, 2'd0);
        send_w_burst("id_conflict", 1, 2'd0);
        // same ID towards another master waits for the first B
        start_aw(aw_second, 2'd1);
        check_aw_held("id_conflict", 6);
        return_b("id_conflict", 0, make_b(5, 2'b00));
        finish_aw("id_conflict", aw_second, 2'd1);
        send_w_burst("id_conflict", 1, 2'd1);
        return_b("id_conflict", 1, make_b(5, 2'b00));
    endtask

    task automatic test_inflight_limit();
        demux_chan_pkg::aw_chan_t aw;
        demux_route_pkg::sel_t    sel;
        for (int i = 0; i < `MAX_TRANS; i++) begin
            aw  = make_aw(i, 0);
            sel = demux_route_pkg::sel_t'(i % `NUM_MST);
            start_aw(aw, sel);
            finish_aw("inflight_limit", aw, sel);
            send_w_burst("inflight_limit", 1, sel);
        end
        // ID 8 shares slot 0 with ID 0 on master 0, so only the total blocks it
        aw = make_aw(8, 0);
        start_aw(aw, 2'd0);
        check_aw_held("inflight_limit", 6);
        return_b("inflight_limit", 3, make_b(3, 2'b00));
        finish_aw("inflight_limit", aw, 2'd0);
        send_w_burst("inflight_limit", 1, 2'd0);
    endtask

    // runs straight after reset with the pointer at master 0
    task automatic test_b_priority();
        demux_chan_pkg::b_chan_t b_low;
        demux_chan_pkg::b_chan_t b_high;
        b_low               = make_b(9, 2'b01);
        b_high              = make_b(12, 2'b11);
        mst_resp[0].b_valid = 1'b1;
        mst_resp[0].b       = b_low;
        mst_resp[2].b_valid = 1'b1;
        mst_resp[2].b       = b_high;
        @(negedge clk_i);
        if (!mst_req[0].b_ready || mst_req[2].b_ready) begin
            fail_run("b_priority: master 0 was not granted alone in the first cycle");
        end
        compare_b("b_priority", b_low);
        wait_drive_point();
        mst_resp[0].b_valid = 1'b0;
        @(negedge clk_i);
        if (!mst_req[2].b_ready) begin
            fail_run("b_priority: master 2 was not granted after master 0");
        end
        compare_b("b_priority", b_high);
        wait_drive_point();
        mst_resp[2].b_valid = 1'b0;
    endtask

    initial begin
        void'($urandom(61479));
        apply_reset();
        test_single_write();
        test_w_order();
        test_id_conflict();
        test_inflight_limit();
        apply_reset();
        test_b_priority();
        repeat (2) @(posedge clk_i);
        pass_seen = 1'b1;
        $display(">>> PASS");
        $finish;
    end

endmodule
